// ==== verilog.f ====
hdl/soc_ctrl_pkg.sv
hdl/pmu_event_packer.sv
hdl/pmu_event_fifo.sv
hdl/pmu_event_drain.sv
hdl/debug_req_gate.sv
hdl/addr_decoder.sv
hdl/soc_ctrl_top.sv
bench/soc_ctrl_properties.sv
bench/soc_ctrl_tb.sv

// ==== bench/soc_ctrl_tb.sv ====
/* Directed testbench for the SoC control top: debug gate,
   address routing and the PMU event path with drops */
`timescale 1ns/10ps

module soc_ctrl_tb;
  import soc_ctrl_pkg::*;

  // Gate window, drop saturation and the remaining tests, doubled
  localparam int MAX_CYCLES = 2 * (DMI_DEL_CYCLES + 400 + 600);
  localparam int DROP_MAX   = 2 ** DROP_CNT_W - 1;

  logic                  clk_i = 1'b0;
  logic                  ndmreset_n;
  logic [NUM_HARTS-1:0]  debug_req_i;
  logic                  req_valid_i;
  logic [ADDR_W-1:0]     req_addr_i;
  logic                  evt_valid_i;
  logic [E_ID_W-1:0]     evt_id_i;
  logic [E_INFO_W-1:0]   evt_info_i;
  logic [S_ID_W-1:0]     evt_src_i;
  logic                  pmu_stall_i;
  logic [NUM_HARTS-1:0]  debug_req_o;
  logic                  route_valid_o;
  logic [SLV_IDX_W-1:0]  route_idx_o;
  logic                  route_err_o;
  pmu_event_u            spu_event_o;
  logic                  spu_event_valid_o;
  logic [DROP_CNT_W-1:0] evt_drop_cnt_o;

  // Debug, ROM, CLINT, PLIC, L2 SPM, HyperBus, LLC SPM
  logic [63:0] map_base [7] = '{64'h0, 64'h1_0000, 64'h200_0000, 64'hC00_0000,
                                64'h1C00_0000, 64'h8000_0000, 64'h7000_0000};
  logic [63:0] map_end [7]  = '{64'h1000, 64'h2_0000, 64'h20C_0000, 64'h1000_0000,
                                64'h1C80_0000, 64'hC000_0000, 64'h7002_0000};
  logic [2:0]  map_idx [7]  = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5};

  logic [31:0]            lcg_state = 32'd49479;
  int                     checks    = 0;
  int                     errors    = 0;
  int                     cycle_cnt = 0;
  int                     exp_drops = 0;
  logic [PMU_EVENT_W-1:0] sent [$];

  soc_ctrl_top soc_ctrl_top_i (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, a test did not finish", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Returns {error, index} from the address table above
  function automatic logic [3:0] model_route(input logic [63:0] addr);
    for (int r = 0; r < 7; r++) begin
      if (addr >= map_base[r] && addr < map_end[r]) return {1'b0, map_idx[r]};
    end
    return 4'b1000;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s done, %0d errors", name, errors - err_start);
  endtask

  task automatic drive_event(output logic [PMU_EVENT_W-1:0] word);
    logic [31:0] r;
    r = rand32();
    evt_id_i = r[E_ID_W-1:0];
    r = rand32();
    evt_info_i = r[E_INFO_W-1:0];
    r = rand32();
    evt_src_i = r[S_ID_W-1:0];
    evt_valid_i = 1'b1;
    word = {evt_id_i, evt_info_i, evt_src_i};
  endtask

  task automatic apply_reset();
    ndmreset_n = 1'b0;
    repeat (2) @(negedge clk_i);
    check_value("debug_req_o", debug_req_o, '0);
    check_value("route_valid_o", route_valid_o, '0);
    check_value("route_err_o", route_err_o, '0);
    check_value("spu_event_valid_o", spu_event_valid_o, '0);
    check_value("spu_event_o", spu_event_o, '0);
    check_value("evt_drop_cnt_o", evt_drop_cnt_o, '0);
    ndmreset_n = 1'b1;
  endtask

  task automatic test_debug_gate();
    logic [31:0] r;
    for (int c = 0; c < DMI_DEL_CYCLES; c++) begin
      check_value("debug_req_o", debug_req_o, '0);
      @(negedge clk_i);
    end
    check_value("debug_req_o", debug_req_o, {NUM_HARTS{1'b1}});
    repeat (8) begin
      r = rand32();
      debug_req_i = r[NUM_HARTS-1:0];
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_o, r[NUM_HARTS-1:0]);
    end
  endtask

  task automatic route_one(input logic [63:0] addr);
    logic [3:0] exp;
    exp = model_route(addr);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    @(negedge clk_i);
    check_value("route_valid_o", route_valid_o, 1'b1);
    check_value("route_err_o", route_err_o, exp[3]);
    check_value("route_idx_o", route_idx_o, exp[2:0]);
    req_valid_i = 1'b0;
  endtask

  task automatic test_route_directed();
    for (int r = 0; r < 7; r++) begin
      route_one(map_base[r]);
      route_one(map_end[r] - 1);
      route_one(map_end[r]);
    end
    route_one(64'h3000_0000);
    @(negedge clk_i);
    check_value("route_valid_o", route_valid_o, 1'b0);
    check_value("route_err_o", route_err_o, 1'b0);
  endtask

  task automatic test_route_random();
    int          r;
    logic [63:0] off;
    logic [63:0] addr;
    logic [31:0] sel;
    repeat (100) begin
      r   = rand32() % 7;
      off = rand32() & 32'hFF;
      // Upper LCG bits, the low ones repeat with a short period
      sel = rand32();
      case (sel[31:30])
        0:       addr = map_base[r] + (rand32() % (map_end[r] - map_base[r]));
        1:       addr = map_end[r] + off;
        2:       addr = map_base[r] - 1 - off;
        default: addr = map_end[r] - 1 - off;
      endcase
      route_one(addr);
    end
  endtask

  // Event driven before edge k shows up after edge k+2
  task automatic test_event_order();
    logic [PMU_EVENT_W-1:0] word;
    sent.delete();
    for (int c = 0; c < 12; c++) begin
      if (c >= 3 && c < 11) begin
        check_value("spu_event_valid_o", spu_event_valid_o, 1'b1);
        check_value("spu_event_o", spu_event_o, sent[c-3]);
      end else begin
        check_value("spu_event_valid_o", spu_event_valid_o, 1'b0);
        check_value("spu_event_o", spu_event_o, '0);
      end
      if (c < 8) begin
        drive_event(word);
        sent.push_back(word);
      end else begin
        evt_valid_i = 1'b0;
      end
      @(negedge clk_i);
    end
  endtask

  // Four events fill the FIFO and each later one is dropped one edge after it is staged
  task automatic stalled_burst(input int n);
    int                     base;
    int                     depth;
    int                     exp;
    logic [PMU_EVENT_W-1:0] word;
    base  = exp_drops;
    depth = SPU_DEPTH;
    sent.delete();
    pmu_stall_i = 1'b1;
    for (int c = 0; c < n + 3; c++) begin
      exp = c - depth - 1;
      if (exp < 0) exp = 0;
      if (exp > n - depth) exp = n - depth;
      exp = base + exp;
      check_value("evt_drop_cnt_o", evt_drop_cnt_o, (exp > DROP_MAX) ? DROP_MAX : exp);
      check_value("spu_event_valid_o", spu_event_valid_o, 1'b0);
      if (c < n) begin
        drive_event(word);
        sent.push_back(word);
      end else begin
        evt_valid_i = 1'b0;
      end
      @(negedge clk_i);
    end
    exp_drops = base + n - depth;
    if (exp_drops > DROP_MAX) exp_drops = DROP_MAX;
  endtask

  task automatic drain_fifo();
    pmu_stall_i = 1'b0;
    for (int c = 0; c < SPU_DEPTH + 2; c++) begin
      @(negedge clk_i);
      if (c < SPU_DEPTH) begin
        check_value("spu_event_valid_o", spu_event_valid_o, 1'b1);
        check_value("spu_event_o", spu_event_o, sent[c]);
      end else begin
        check_value("spu_event_valid_o", spu_event_valid_o, 1'b0);
        check_value("spu_event_o", spu_event_o, '0);
      end
    end
    check_value("evt_drop_cnt_o", evt_drop_cnt_o, exp_drops);
  endtask

  initial begin
    int e0;
    ndmreset_n  = 1'b0;
    debug_req_i = '1;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    evt_valid_i = 1'b0;
    evt_id_i    = '0;
    evt_info_i  = '0;
    evt_src_i   = '0;
    pmu_stall_i = 1'b0;
    apply_reset();
    e0 = errors;
    test_debug_gate();
    report_test("debug gate", e0);
    e0 = errors;
    test_route_directed();
    report_test("directed routing", e0);
    e0 = errors;
    test_route_random();
    report_test("random routing", e0);
    e0 = errors;
    test_event_order();
    report_test("event order", e0);
    e0 = errors;
    stalled_burst(6);
    drain_fifo();
    report_test("back-pressure", e0);
    e0 = errors;
    stalled_burst(300);
    drain_fifo();
    report_test("drop saturation", e0);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== bench/soc_ctrl_properties.sv ====
/* Concurrent assertions on the SoC control top outputs */
`timescale 1ns/10ps

module soc_ctrl_properties (
  input logic                                clk_i,
  input logic                                ndmreset_n,
  input logic [soc_ctrl_pkg::NUM_HARTS-1:0]  debug_req_o,
  input logic                                route_valid_o,
  input logic                                route_err_o,
  input soc_ctrl_pkg::pmu_event_u            spu_event_o,
  input logic                                spu_event_valid_o,
  input logic [soc_ctrl_pkg::DROP_CNT_W-1:0] evt_drop_cnt_o
);
  import soc_ctrl_pkg::*;

  logic [$clog2(DMI_DEL_CYCLES+1)-1:0] cyc_q;

  // Edges since reset release, stops at the hold-off length
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cyc_q <= '0;
    end else if (cyc_q != DMI_DEL_CYCLES) begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !spu_event_valid_o |-> (spu_event_o == '0))
    else $error("spu_event_o is nonzero while spu_event_valid_o is low");

  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    route_err_o |-> route_valid_o)
    else $error("route_err_o is high without route_valid_o");

  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    evt_drop_cnt_o >= $past(evt_drop_cnt_o))
    else $error("evt_drop_cnt_o went down outside reset");

  assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cyc_q < DMI_DEL_CYCLES) |-> (debug_req_o == '0))
    else $error("debug_req_o is set inside the hold-off window");

endmodule

bind soc_ctrl_top soc_ctrl_properties soc_ctrl_properties_i (.*);

// ==== hdl/soc_ctrl_top.sv ====
/* SoC control top: PMU event path, debug request gate
   and address decoder */
`timescale 1ns/10ps

module soc_ctrl_top (
  input  logic                                 clk_i,
  input  logic                                 ndmreset_n,
  input  logic [soc_ctrl_pkg::NUM_HARTS-1:0]   debug_req_i,
  input  logic                                 req_valid_i,
  input  logic [soc_ctrl_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic                                 evt_valid_i,
  input  logic [soc_ctrl_pkg::E_ID_W-1:0]      evt_id_i,
  input  logic [soc_ctrl_pkg::E_INFO_W-1:0]    evt_info_i,
  input  logic [soc_ctrl_pkg::S_ID_W-1:0]      evt_src_i,
  input  logic                                 pmu_stall_i,
  output logic [soc_ctrl_pkg::NUM_HARTS-1:0]   debug_req_o,
  output logic                                 route_valid_o,
  output logic [soc_ctrl_pkg::SLV_IDX_W-1:0]   route_idx_o,
  output logic                                 route_err_o,
  output soc_ctrl_pkg::pmu_event_u             spu_event_o,
  output logic                                 spu_event_valid_o,
  output logic [soc_ctrl_pkg::DROP_CNT_W-1:0]  evt_drop_cnt_o
);
  import soc_ctrl_pkg::*;

  logic       push;
  pmu_event_u push_data;
  logic       full;
  logic       pop;
  pmu_event_u pop_data;
  logic       empty;

  // ------------------------------------------------------------
  // PMU event path
  // ------------------------------------------------------------
  pmu_event_packer i_pmu_event_packer (
    .clk_i       ( clk_i          ),
    .ndmreset_n  ( ndmreset_n     ),
    .evt_valid_i ( evt_valid_i    ),
    .evt_id_i    ( evt_id_i       ),
    .evt_info_i  ( evt_info_i     ),
    .evt_src_i   ( evt_src_i      ),
    .full_i      ( full           ),
    .push_o      ( push           ),
    .push_data_o ( push_data      ),
    .drop_cnt_o  ( evt_drop_cnt_o )
  );

  pmu_event_fifo i_pmu_event_fifo (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .full_o      ( full       ),
    .pop_i       ( pop        ),
    .pop_data_o  ( pop_data   ),
    .empty_o     ( empty      )
  );

  pmu_event_drain i_pmu_event_drain (
    .clk_i             ( clk_i             ),
    .ndmreset_n        ( ndmreset_n        ),
    .empty_i           ( empty             ),
    .pop_data_i        ( pop_data          ),
    .pmu_stall_i       ( pmu_stall_i       ),
    .pop_o             ( pop               ),
    .spu_event_o       ( spu_event_o       ),
    .spu_event_valid_o ( spu_event_valid_o )
  );

  // ------------------------------------------------------------
  // Debug gate and address decode
  // ------------------------------------------------------------
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  addr_decoder i_addr_decoder (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .req_valid_i   ( req_valid_i   ),
    .req_addr_i    ( req_addr_i    ),
    .route_valid_o ( route_valid_o ),
    .route_idx_o   ( route_idx_o   ),
    .route_err_o   ( route_err_o   )
  );

endmodule

// ==== hdl/addr_decoder.sv ====
/* Registered address map lookup, returns the peripheral
   index of the matching rule or a decode error */
`timescale 1ns/10ps

module addr_decoder (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  input  logic                               req_valid_i,
  input  logic [soc_ctrl_pkg::ADDR_W-1:0]    req_addr_i,
  output logic                               route_valid_o,
  output logic [soc_ctrl_pkg::SLV_IDX_W-1:0] route_idx_o,
  output logic                               route_err_o
);
  import soc_ctrl_pkg::*;

  logic                 hit;
  logic [SLV_IDX_W-1:0] hit_idx;
  logic                 route_valid_q;
  logic [SLV_IDX_W-1:0] route_idx_q;
  logic                 route_err_q;

  // Rules are disjoint, at most one of them matches
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int r = 0; r < NUM_RULES; r++) begin
      if ((req_addr_i >= RULE_BASE[r]) && (req_addr_i < RULE_END[r])) begin
        hit     = 1'b1;
        hit_idx = RULE_IDX[r];
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      route_valid_q <= 1'b0;
      route_idx_q   <= '0;
      route_err_q   <= 1'b0;
    end else begin
      route_valid_q <= req_valid_i;
      route_idx_q   <= (req_valid_i && hit) ? hit_idx : '0;
      route_err_q   <= req_valid_i & ~hit;
    end
  end

  assign route_valid_o = route_valid_q;
  assign route_idx_o   = route_idx_q;
  assign route_err_o   = route_err_q;

endmodule

// ==== hdl/debug_req_gate.sv ====
/* Post-reset hold-off of the per-hart debug requests */
`timescale 1ns/10ps

module debug_req_gate (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  input  logic [soc_ctrl_pkg::NUM_HARTS-1:0] debug_req_i,
  output logic [soc_ctrl_pkg::NUM_HARTS-1:0] debug_req_o
);
  import soc_ctrl_pkg::*;

  logic [$clog2(DMI_DEL_CYCLES+1)-1:0] del_cnt_q;
  logic                                hold;

  // Gives boot code time to set up before a halt can hit the cores
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= ($bits(del_cnt_q))'(DMI_DEL_CYCLES);
    end else if (hold) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign hold = (del_cnt_q != '0);

  assign debug_req_o = hold ? '0 : debug_req_i;

endmodule

// ==== hdl/pmu_event_drain.sv ====
/* PMU event consumer: pops the FIFO when the PMU is ready
   and drives a masked event word with its valid flag */
`timescale 1ns/10ps

module pmu_event_drain (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     empty_i,
  input  soc_ctrl_pkg::pmu_event_u pop_data_i,
  input  logic                     pmu_stall_i,
  output logic                     pop_o,
  output soc_ctrl_pkg::pmu_event_u spu_event_o,
  output logic                     spu_event_valid_o
);
  import soc_ctrl_pkg::*;

  logic       valid_q;
  pmu_event_u data_q;

  assign pop_o = ~empty_i & ~pmu_stall_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      data_q <= pop_data_i;
    end
  end

  // Idle output reads as all zeros
  assign spu_event_o.raw   = data_q.raw & {PMU_EVENT_W{valid_q}};
  assign spu_event_valid_o = valid_q;

endmodule

// ==== hdl/pmu_event_fifo.sv ====
/* Four-entry single-clock FIFO for PMU event words,
   binary read and write pointers with a wrap bit */
`timescale 1ns/10ps

module pmu_event_fifo (
  input  logic                     clk_i,
  input  logic                     ndmreset_n,
  input  logic                     push_i,
  input  soc_ctrl_pkg::pmu_event_u push_data_i,
  output logic                     full_o,
  input  logic                     pop_i,
  output soc_ctrl_pkg::pmu_event_u pop_data_o,
  output logic                     empty_o
);
  import soc_ctrl_pkg::*;

  pmu_event_u             mem_q [SPU_DEPTH];
  logic [LOG_DEPTH_SPU:0] wptr_q;
  logic [LOG_DEPTH_SPU:0] rptr_q;
  logic                   push_ok;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  assign push_ok = push_i & ~full_o;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wptr_q[LOG_DEPTH_SPU-1:0]] <= push_data_i;
    end
  end

  // ------------------------------------------------------------
  // Pointers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wptr_q <= '0;
    end else if (push_ok) begin
      wptr_q <= wptr_q + 1'b1;
    end
  end

  // Consumer guarantees the FIFO is not empty when it pops
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rptr_q <= '0;
    end else if (pop_i) begin
      rptr_q <= rptr_q + 1'b1;
    end
  end

  // Same index, wrap bits differ means full
  assign full_o  = (wptr_q[LOG_DEPTH_SPU] != rptr_q[LOG_DEPTH_SPU]) &&
                   (wptr_q[LOG_DEPTH_SPU-1:0] == rptr_q[LOG_DEPTH_SPU-1:0]);
  assign empty_o = (wptr_q == rptr_q);

  // Oldest entry
  assign pop_data_o = mem_q[rptr_q[LOG_DEPTH_SPU-1:0]];

endmodule

// ==== hdl/pmu_event_packer.sv ====
/* PMU event producer: stage register for core events,
   push into the event FIFO and saturating drop counter */
`timescale 1ns/10ps

module pmu_event_packer (
  input  logic                                 clk_i,
  input  logic                                 ndmreset_n,
  input  logic                                 evt_valid_i,
  input  logic [soc_ctrl_pkg::E_ID_W-1:0]      evt_id_i,
  input  logic [soc_ctrl_pkg::E_INFO_W-1:0]    evt_info_i,
  input  logic [soc_ctrl_pkg::S_ID_W-1:0]      evt_src_i,
  input  logic                                 full_i,
  output logic                                 push_o,
  output soc_ctrl_pkg::pmu_event_u             push_data_o,
  output logic [soc_ctrl_pkg::DROP_CNT_W-1:0]  drop_cnt_o
);
  import soc_ctrl_pkg::*;

  logic                  stage_valid_q;
  pmu_event_u            stage_q;
  logic                  drop;
  logic [DROP_CNT_W-1:0] drop_cnt_q;

  // Stage is rewritten every cycle, it never waits for the FIFO
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      stage_valid_q <= 1'b0;
    end else begin
      stage_valid_q <= evt_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (evt_valid_i) begin
      stage_q.fields.e_id   <= evt_id_i;
      stage_q.fields.e_info <= evt_info_i;
      stage_q.fields.s_id   <= evt_src_i;
    end
  end

  assign push_o      = stage_valid_q;
  assign push_data_o = stage_q;

  // Staged event lost when the FIFO has no room
  assign drop = stage_valid_q & full_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      drop_cnt_q <= '0;
    end else if (drop && (drop_cnt_q != '1)) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign drop_cnt_o = drop_cnt_q;

endmodule

// ==== hdl/soc_ctrl_pkg.sv ====
/* Widths, FIFO depth, debug hold-off window, address map rules
   and the PMU event word used by the SoC control block */
package soc_ctrl_pkg;

  // ------------------------------------------------------------
  // Debug request hold-off
  // ------------------------------------------------------------
  localparam int unsigned NUM_HARTS      = 2;
  localparam int unsigned DMI_DEL_CYCLES = 500;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam int unsigned ADDR_W    = 64;
  localparam int unsigned SLV_IDX_W = 3;
  localparam int unsigned NUM_RULES = 7;

  // Debug, ROM, CLINT, PLIC, L2 SPM, HyperBus, LLC SPM
  localparam logic [ADDR_W-1:0] RULE_BASE [NUM_RULES] = '{
    64'h0000_0000_0000_0000,
    64'h0000_0000_0001_0000,
    64'h0000_0000_0200_0000,
    64'h0000_0000_0C00_0000,
    64'h0000_0000_1C00_0000,
    64'h0000_0000_8000_0000,
    64'h0000_0000_7000_0000
  };

  // End addresses are exclusive
  localparam logic [ADDR_W-1:0] RULE_END [NUM_RULES] = '{
    64'h0000_0000_0000_1000,
    64'h0000_0000_0002_0000,
    64'h0000_0000_020C_0000,
    64'h0000_0000_1000_0000,
    64'h0000_0000_1C80_0000,
    64'h0000_0000_C000_0000,
    64'h0000_0000_7002_0000
  };

  // LLC scratchpad shares the HyperBus port
  localparam logic [SLV_IDX_W-1:0] RULE_IDX [NUM_RULES] = '{
    3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5
  };

  // ------------------------------------------------------------
  // PMU event path
  // ------------------------------------------------------------
  localparam int unsigned E_ID_W        = 4;
  localparam int unsigned E_INFO_W      = 17;
  localparam int unsigned S_ID_W        = 8;
  localparam int unsigned PMU_EVENT_W   = E_ID_W + E_INFO_W + S_ID_W;
  localparam int unsigned LOG_DEPTH_SPU = 2;
  localparam int unsigned SPU_DEPTH     = 2 ** LOG_DEPTH_SPU;
  localparam int unsigned DROP_CNT_W    = 8;

  // Field view for the producer, raw view for masking at the output
  typedef union packed {
    struct packed {
      logic [E_ID_W-1:0]   e_id;
      logic [E_INFO_W-1:0] e_info;
      logic [S_ID_W-1:0]   s_id;
    } fields;
    logic [PMU_EVENT_W-1:0] raw;
  } pmu_event_u;

endpackage
